// File: hdl/mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

  // Core data port widths
  localparam int WORD_WIDTH = 32;
  localparam int STRB_WIDTH = WORD_WIDTH / 8;
  localparam int ADDR_WIDTH = 25;

  typedef logic [WORD_WIDTH-1:0] word_t;
  typedef logic [STRB_WIDTH-1:0] strb_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // All byte lanes enabled
  localparam strb_t STRB_FULL = '1;

  // Bytes per word for byte address to word index conversion
  localparam int WORD_BYTES = STRB_WIDTH;
  localparam int WORD_SHIFT = $clog2(WORD_BYTES);

  //////////////////////////////
  // Broadcast message layout
  //////////////////////////////

  // Data in the low bits, then the strobe, then the region word offset
  localparam int MSG_DATA_LSB = 0;
  localparam int MSG_STRB_LSB = MSG_DATA_LSB + WORD_WIDTH;
  localparam int MSG_OFF_LSB  = MSG_STRB_LSB + STRB_WIDTH;

endpackage

`default_nettype wire

// File: hdl/accel_pkg.sv
`default_nettype none

package accel_pkg;

  // Register offsets matched against the low address byte
  localparam int ACC_OFF_WIDTH = 8;

  typedef logic [ACC_OFF_WIDTH-1:0] acc_off_t;

  localparam acc_off_t ACC_REG_SUM   = 8'h00;
  localparam acc_off_t ACC_REG_DATA  = 8'h04;
  localparam acc_off_t ACC_REG_COUNT = 8'h08;

  // Ones'-complement checksum value
  typedef logic [15:0] csum_t;

  // Accelerator error state
  typedef enum logic {
    ACC_IDLE = 1'b0,
    ACC_ERR  = 1'b1
  } acc_state_t;

endpackage

`default_nettype wire

// File: hdl/data_mem.sv
`timescale 1ns/10ps
`default_nettype none

module data_mem #(
  parameter int DMEM_WORDS     = 1024,
  parameter int BC_WORDS       = 64,
  parameter int MSG_ADDR_WIDTH = 6,
  parameter int MSG_WIDTH      = 42
) (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   dmem_en,
  input  wire logic                   wen,
  input  wire mem_map_pkg::strb_t     strb,
  input  wire mem_map_pkg::addr_t     addr,
  input  wire mem_map_pkg::word_t     wr_data,
  input  wire logic [MSG_WIDTH-1:0]   bc_msg_in,
  input  wire logic                   bc_msg_in_valid,
  output mem_map_pkg::word_t          rd_data,
  output logic                        rd_valid
);

  import mem_map_pkg::*;

  localparam int DMEM_AW = $clog2(DMEM_WORDS);
  localparam int BC_BASE = DMEM_WORDS - BC_WORDS;

  word_t mem [DMEM_WORDS];

  logic [DMEM_AW-1:0]        core_idx;
  logic [DMEM_AW-1:0]        msg_idx;
  word_t                     msg_data;
  strb_t                     msg_strb;
  logic [MSG_ADDR_WIDTH-1:0] msg_off;

  assign core_idx = addr[DMEM_AW+WORD_SHIFT-1:WORD_SHIFT];

  // Unpack incoming message
  assign msg_data = bc_msg_in[MSG_DATA_LSB +: WORD_WIDTH];
  assign msg_strb = bc_msg_in[MSG_STRB_LSB +: STRB_WIDTH];
  assign msg_off  = bc_msg_in[MSG_OFF_LSB +: MSG_ADDR_WIDTH];
  assign msg_idx  = DMEM_AW'(BC_BASE) + DMEM_AW'(msg_off);

  // Core bytes first, message bytes second so they win on a collision
  always_ff @(posedge clk) begin
    if (dmem_en && wen) begin
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (strb[i]) begin
          mem[core_idx][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
    if (bc_msg_in_valid) begin
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (msg_strb[i]) begin
          mem[msg_idx][8*i +: 8] <= msg_data[8*i +: 8];
        end
      end
    end
  end

  // Registered read with one cycle of latency
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_data  <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= dmem_en && !wen;
      if (dmem_en && !wen) begin
        rd_data <= mem[core_idx];
      end
    end
  end

  // Core must stay inside the physical memory
  a_dmem_in_range: assert property (
    @(posedge clk) disable iff (rst)
    dmem_en |-> (addr[ADDR_WIDTH-1:WORD_SHIFT] < DMEM_WORDS)
  ) else $error("data_mem access past DMEM_WORDS, addr %h", addr);

endmodule

`default_nettype wire

// File: hdl/csum_accel.sv
`timescale 1ns/10ps
`default_nettype none

module csum_accel (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               exio_en,
  input  wire logic               wen,
  input  wire mem_map_pkg::strb_t strb,
  input  wire mem_map_pkg::addr_t addr,
  input  wire mem_map_pkg::word_t wr_data,
  input  wire logic               err_ack,
  output mem_map_pkg::word_t      rd_data,
  output logic                    rd_valid,
  output logic                    err
);

  import mem_map_pkg::*;
  import accel_pkg::*;

  acc_state_t state;
  csum_t      sum;
  word_t      count;

  acc_off_t   off;
  logic       hit_sum;
  logic       hit_data;
  logic       hit_count;
  logic       bad_acc;
  logic       wr_ok;
  logic [17:0] add_full;
  logic [16:0] fold;
  csum_t      sum_next;

  //////////////////////////////
  // Decode
  //////////////////////////////

  assign off       = addr[ACC_OFF_WIDTH-1:0];
  assign hit_sum   = (off == ACC_REG_SUM);
  assign hit_data  = (off == ACC_REG_DATA);
  assign hit_count = (off == ACC_REG_COUNT);

  // Unknown offset, or a write that is not full word
  assign bad_acc = exio_en &&
                   (!(hit_sum || hit_data || hit_count) || (wen && strb != STRB_FULL));
  assign wr_ok   = exio_en && wen && !bad_acc;

  // Both halves in, then fold the carries back twice
  assign add_full = {2'b00, sum} + {2'b00, wr_data[15:0]} + {2'b00, wr_data[31:16]};
  assign fold     = {1'b0, add_full[15:0]} + {15'd0, add_full[17:16]};
  assign sum_next = fold[15:0] + {15'd0, fold[16]};

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      sum   <= '0;
      count <= '0;
    end else if (wr_ok) begin
      if (hit_sum) begin
        sum   <= wr_data[15:0];
        count <= '0;
      end else if (hit_data) begin
        sum   <= sum_next;
        count <= count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= exio_en && !wen;
    end
  end

  // DATA and bad offsets read back as zero
  always_ff @(posedge clk) begin
    if (exio_en && !wen) begin
      if (!bad_acc && hit_sum) begin
        rd_data <= {16'd0, sum};
      end else if (!bad_acc && hit_count) begin
        rd_data <= count;
      end else begin
        rd_data <= '0;
      end
    end
  end

  // Error latch held until acknowledged
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ACC_IDLE;
    end else begin
      case (state)
        ACC_IDLE: if (bad_acc) state <= ACC_ERR;
        ACC_ERR:  if (err_ack && !bad_acc) state <= ACC_IDLE;
        default:  state <= ACC_IDLE;
      endcase
    end
  end

  assign err = (state == ACC_ERR);

endmodule

`default_nettype wire

// File: hdl/core_port.sv
`timescale 1ns/10ps
`default_nettype none

module core_port #(
  parameter int                 MSG_WIDTH      = 42,
  parameter int                 MSG_ADDR_WIDTH = 6,
  parameter mem_map_pkg::addr_t BC_START       = 25'h0f00
) (
  input  wire logic               clk,
  input  wire logic               dmem_en,
  input  wire logic               exio_en,
  input  wire logic               wen,
  input  wire mem_map_pkg::strb_t strb,
  input  wire mem_map_pkg::addr_t addr,
  input  wire mem_map_pkg::word_t wr_data,
  input  wire mem_map_pkg::word_t dmem_rd_data,
  input  wire logic               dmem_rd_valid,
  input  wire mem_map_pkg::word_t exio_rd_data,
  input  wire logic               exio_rd_valid,
  output mem_map_pkg::word_t      mem_rd_data,
  output logic                    mem_rd_valid,
  output logic [MSG_WIDTH-1:0]    bc_msg_out,
  output logic                    bc_msg_out_valid
);

  import mem_map_pkg::*;

  addr_t bc_rel;

  // Accelerator data takes the read port when it is valid
  assign mem_rd_data  = exio_rd_valid ? exio_rd_data : dmem_rd_data;
  assign mem_rd_valid = exio_rd_valid || dmem_rd_valid;

  // Offset of the store inside the broadcast region
  assign bc_rel = addr - BC_START;

  assign bc_msg_out[MSG_DATA_LSB +: WORD_WIDTH]    = wr_data;
  assign bc_msg_out[MSG_STRB_LSB +: STRB_WIDTH]    = strb;
  assign bc_msg_out[MSG_OFF_LSB +: MSG_ADDR_WIDTH] =
    bc_rel[MSG_ADDR_WIDTH+WORD_SHIFT-1:WORD_SHIFT];

  assign bc_msg_out_valid = dmem_en && wen && (addr >= BC_START);

  // Core issues to one target at a time
  a_en_excl: assert property (
    @(posedge clk) !(dmem_en && exio_en)
  ) else $error("dmem_en and exio_en high together");

  // Returns from the two blocks never overlap
  a_rd_valid_excl: assert property (
    @(posedge clk) !(dmem_rd_valid && exio_rd_valid)
  ) else $error("dmem and exio read returns collide");

endmodule

`default_nettype wire

// File: hdl/riscv_block.sv
`timescale 1ns/10ps
`default_nettype none

module riscv_block #(
  parameter  int DMEM_WORDS     = 1024,
  parameter  int BC_WORDS       = 64,
  localparam int MSG_ADDR_WIDTH = $clog2(BC_WORDS),
  localparam int MSG_WIDTH      = mem_map_pkg::MSG_OFF_LSB + MSG_ADDR_WIDTH
) (
  input  wire logic                 clk,
  input  wire logic                 rst,

  // Core data port
  input  wire logic                 dmem_en,
  input  wire logic                 exio_en,
  input  wire logic                 mem_wen,
  input  wire mem_map_pkg::strb_t   mem_strb,
  input  wire mem_map_pkg::addr_t   mem_addr,
  input  wire mem_map_pkg::word_t   mem_wr_data,
  output mem_map_pkg::word_t        mem_rd_data,
  output logic                      mem_rd_valid,

  // Broadcast messages
  input  wire logic [MSG_WIDTH-1:0] bc_msg_in,
  input  wire logic                 bc_msg_in_valid,
  output logic [MSG_WIDTH-1:0]      bc_msg_out,
  output logic                      bc_msg_out_valid,

  // Accelerator error
  output logic                      ext_io_err,
  input  wire logic                 ext_io_err_ack
);

  import mem_map_pkg::*;

  // Byte address of the first shared word
  localparam addr_t BC_START = addr_t'((DMEM_WORDS - BC_WORDS) * WORD_BYTES);

  word_t dmem_rd_data;
  logic  dmem_rd_valid;
  word_t exio_rd_data;
  logic  exio_rd_valid;

  //////////////////////////////
  // Local data memory
  //////////////////////////////

  data_mem #(
    .DMEM_WORDS(DMEM_WORDS),
    .BC_WORDS(BC_WORDS),
    .MSG_ADDR_WIDTH(MSG_ADDR_WIDTH),
    .MSG_WIDTH(MSG_WIDTH)
  ) u_data_mem (
    .clk(clk),
    .rst(rst),
    .dmem_en(dmem_en),
    .wen(mem_wen),
    .strb(mem_strb),
    .addr(mem_addr),
    .wr_data(mem_wr_data),
    .bc_msg_in(bc_msg_in),
    .bc_msg_in_valid(bc_msg_in_valid),
    .rd_data(dmem_rd_data),
    .rd_valid(dmem_rd_valid)
  );

  //////////////////////////////
  // Checksum accelerator
  //////////////////////////////

  csum_accel u_csum_accel (
    .clk(clk),
    .rst(rst),
    .exio_en(exio_en),
    .wen(mem_wen),
    .strb(mem_strb),
    .addr(mem_addr),
    .wr_data(mem_wr_data),
    .err_ack(ext_io_err_ack),
    .rd_data(exio_rd_data),
    .rd_valid(exio_rd_valid),
    .err(ext_io_err)
  );

  // Read merge and outgoing messages
  core_port #(
    .MSG_WIDTH(MSG_WIDTH),
    .MSG_ADDR_WIDTH(MSG_ADDR_WIDTH),
    .BC_START(BC_START)
  ) u_core_port (
    .clk(clk),
    .dmem_en(dmem_en),
    .exio_en(exio_en),
    .wen(mem_wen),
    .strb(mem_strb),
    .addr(mem_addr),
    .wr_data(mem_wr_data),
    .dmem_rd_data(dmem_rd_data),
    .dmem_rd_valid(dmem_rd_valid),
    .exio_rd_data(exio_rd_data),
    .exio_rd_valid(exio_rd_valid),
    .mem_rd_data(mem_rd_data),
    .mem_rd_valid(mem_rd_valid),
    .bc_msg_out(bc_msg_out),
    .bc_msg_out_valid(bc_msg_out_valid)
  );

endmodule

`default_nettype wire

// File: bench/riscv_block_tb.sv
`timescale 1ns/10ps
`default_nettype none

module riscv_block_tb;

  import mem_map_pkg::*;
  import accel_pkg::*;

  localparam int DMEM_WORDS = 1024;
  localparam int BC_WORDS   = 64;
  localparam int MSG_AW     = $clog2(BC_WORDS);
  localparam int MSG_W      = 36 + MSG_AW;

  typedef logic [$clog2(DMEM_WORDS)-1:0] widx_t;
  typedef logic [MSG_AW-1:0]             msg_off_t;

  // First word of the broadcast region
  localparam widx_t BC_BASE = widx_t'(DMEM_WORDS - BC_WORDS);

  logic             clk;
  logic             rst;
  logic             dmem_en;
  logic             exio_en;
  logic             mem_wen;
  strb_t            mem_strb;
  addr_t            mem_addr;
  word_t            mem_wr_data;
  logic [MSG_W-1:0] bc_msg_in;
  logic             bc_msg_in_valid;
  logic             ext_io_err_ack;
  word_t            mem_rd_data;
  logic             mem_rd_valid;
  logic [MSG_W-1:0] bc_msg_out;
  logic             bc_msg_out_valid;
  logic             ext_io_err;

  // Reference state
  word_t    shadow [DMEM_WORDS];
  word_t    exp_rd_q [$];
  logic     exp_msg_valid;
  word_t    exp_msg_data;
  strb_t    exp_msg_strb;
  msg_off_t exp_msg_off;
  csum_t    model_sum;
  word_t    model_count;

  riscv_block #(
    .DMEM_WORDS(DMEM_WORDS),
    .BC_WORDS(BC_WORDS)
  ) u_riscv_block (
    .clk(clk),
    .rst(rst),
    .dmem_en(dmem_en),
    .exio_en(exio_en),
    .mem_wen(mem_wen),
    .mem_strb(mem_strb),
    .mem_addr(mem_addr),
    .mem_wr_data(mem_wr_data),
    .mem_rd_data(mem_rd_data),
    .mem_rd_valid(mem_rd_valid),
    .bc_msg_in(bc_msg_in),
    .bc_msg_in_valid(bc_msg_in_valid),
    .bc_msg_out(bc_msg_out),
    .bc_msg_out_valid(bc_msg_out_valid),
    .ext_io_err(ext_io_err),
    .ext_io_err_ack(ext_io_err_ack)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Ones'-complement add of both halves with the carry folded back after each
  function automatic csum_t csum_add(csum_t sum, word_t w);
    int unsigned t;
    t = 32'(sum) + 32'(w[15:0]);
    t = (t & 32'hffff) + (t >> 16);
    t = t + 32'(w[31:16]);
    t = (t & 32'hffff) + (t >> 16);
    return csum_t'(t);
  endfunction

  function automatic word_t merge_bytes(word_t old, word_t data, strb_t s);
    word_t mask;
    mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    return (old & ~mask) | (data & mask);
  endfunction

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_word(input word_t act, input word_t exp, input string what);
    if (act !== exp) begin
      stop_run($sformatf("error at %0t: %s is %h, expected %h", $time, what, act, exp));
    end
  endtask

  task automatic check_msg(input word_t data, input strb_t strb, input msg_off_t off);
    if (bc_msg_out[31:0] !== data || bc_msg_out[35:32] !== strb ||
        bc_msg_out[MSG_W-1:36] !== off) begin
      stop_run($sformatf("error at %0t: message %h, expected data %h strobe %h offset %0d",
                         $time, bc_msg_out, data, strb, off));
    end
  endtask

  task automatic check_err(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      stop_run($sformatf("error at %0t: %s is %b, expected %b", $time, what, act, exp));
    end
  endtask

  // Outputs sampled on the rising edge while inputs change on the falling one
  always @(posedge clk) begin
    if (!rst) begin
      if (mem_rd_valid) begin
        if (exp_rd_q.size() == 0) begin
          stop_run("read data came back with no read pending");
        end else begin
          check_word(mem_rd_data, exp_rd_q.pop_front(), "read data");
        end
      end
      check_err(bc_msg_out_valid, exp_msg_valid, "broadcast message valid");
      if (exp_msg_valid) begin
        check_msg(exp_msg_data, exp_msg_strb, exp_msg_off);
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic drive_idle();
    dmem_en         = 1'b0;
    exio_en         = 1'b0;
    mem_wen         = 1'b0;
    mem_strb        = '0;
    mem_addr        = '0;
    mem_wr_data     = '0;
    bc_msg_in       = '0;
    bc_msg_in_valid = 1'b0;
    ext_io_err_ack  = 1'b0;
    exp_msg_valid   = 1'b0;
  endtask

  // Read data must show up on the second rising edge after the request
  task automatic wait_read(input string what);
    int n;
    n = 0;
    @(negedge clk);
    drive_idle();
    while (exp_rd_q.size() != 0 && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (exp_rd_q.size() != 0) begin
      stop_run($sformatf("timeout waiting for read data of %s", what));
    end else if (n != 1) begin
      stop_run($sformatf("read data of %s did not come one cycle after the request", what));
    end
  endtask

  task automatic wait_err(input logic level, input string what);
    int n;
    n = 0;
    @(negedge clk);
    drive_idle();
    while (ext_io_err !== level && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (ext_io_err !== level) begin
      stop_run($sformatf("timeout waiting for %s", what));
    end
  endtask

  task automatic dmem_write(input widx_t idx, input strb_t s, input word_t d);
    @(negedge clk);
    drive_idle();
    dmem_en     = 1'b1;
    mem_wen     = 1'b1;
    mem_addr    = addr_t'({idx, 2'b00});
    mem_strb    = s;
    mem_wr_data = d;
    if (idx >= BC_BASE) begin
      exp_msg_valid = 1'b1;
      exp_msg_data  = d;
      exp_msg_strb  = s;
      exp_msg_off   = msg_off_t'(idx - BC_BASE);
    end
    shadow[idx] = merge_bytes(shadow[idx], d, s);
  endtask

  // Message in the current cycle, applied after any core store
  task automatic msg_drive(input msg_off_t off, input strb_t s, input word_t d);
    widx_t idx;
    idx             = BC_BASE + widx_t'(off);
    bc_msg_in       = {off, s, d};
    bc_msg_in_valid = 1'b1;
    shadow[idx]     = merge_bytes(shadow[idx], d, s);
  endtask

  task automatic dmem_read(input widx_t idx);
    @(negedge clk);
    drive_idle();
    dmem_en  = 1'b1;
    mem_addr = addr_t'({idx, 2'b00});
    exp_rd_q.push_back(shadow[idx]);
    wait_read($sformatf("data memory word %0d", idx));
  endtask

  task automatic acc_write(input acc_off_t off, input strb_t s, input word_t d);
    @(negedge clk);
    drive_idle();
    exio_en     = 1'b1;
    mem_wen     = 1'b1;
    mem_addr    = addr_t'(off);
    mem_strb    = s;
    mem_wr_data = d;
    if (s == STRB_FULL && off == ACC_REG_SUM) begin
      model_sum   = d[15:0];
      model_count = '0;
    end else if (s == STRB_FULL && off == ACC_REG_DATA) begin
      model_sum   = csum_add(model_sum, d);
      model_count = model_count + word_t'(1);
    end
  endtask

  task automatic acc_read(input acc_off_t off);
    @(negedge clk);
    drive_idle();
    exio_en  = 1'b1;
    mem_addr = addr_t'(off);
    if (off == ACC_REG_SUM) begin
      exp_rd_q.push_back({16'd0, model_sum});
    end else if (off == ACC_REG_COUNT) begin
      exp_rd_q.push_back(model_count);
    end else begin
      exp_rd_q.push_back('0);
    end
    wait_read($sformatf("accelerator offset %h", off));
  endtask

  task automatic ack_err();
    @(negedge clk);
    drive_idle();
    ext_io_err_ack = 1'b1;
    wait_err(1'b0, "error flag to clear after ack");
  endtask

  initial begin
    widx_t    lw [$];
    msg_off_t off;
    int       j;
    void'($urandom(32'hb51b));
    rst         = 1'b1;
    model_sum   = '0;
    model_count = '0;
    drive_idle();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_err(ext_io_err, 1'b0, "error flag after reset");
    check_err(mem_rd_valid, 1'b0, "read valid after reset");

    // Random strobes over a small set of local words
    for (int i = 0; i < 16; i++) begin
      lw.push_back(widx_t'($urandom_range(DMEM_WORDS - BC_WORDS - 1, 0)));
      dmem_write(lw[i], STRB_FULL, word_t'($urandom));
    end
    for (int i = 0; i < 80; i++) begin
      j = int'($urandom_range(15, 0));
      if ($urandom_range(1, 0) == 1) begin
        dmem_write(lw[j], strb_t'($urandom_range(15, 1)), word_t'($urandom));
      end else begin
        dmem_read(lw[j]);
      end
    end
    for (int i = 0; i < 16; i++) begin
      dmem_read(lw[i]);
    end

    // Each broadcast region store sends a message
    for (int i = 0; i < BC_WORDS; i++) begin
      dmem_write(BC_BASE + widx_t'(i), STRB_FULL, word_t'($urandom));
    end
    for (int i = 0; i < 20; i++) begin
      off = msg_off_t'($urandom_range(BC_WORDS - 1, 0));
      dmem_write(BC_BASE + widx_t'(off), strb_t'($urandom_range(15, 1)), word_t'($urandom));
      dmem_read(BC_BASE + widx_t'(off));
    end
    dmem_write(BC_BASE - widx_t'(1), STRB_FULL, word_t'($urandom));
    dmem_read(BC_BASE - widx_t'(1));

    // Incoming messages alone and colliding with a core store
    for (int i = 0; i < 20; i++) begin
      off = msg_off_t'($urandom_range(BC_WORDS - 1, 0));
      @(negedge clk);
      drive_idle();
      msg_drive(off, strb_t'($urandom_range(15, 1)), word_t'($urandom));
      dmem_read(BC_BASE + widx_t'(off));
    end
    for (int i = 0; i < 12; i++) begin
      off = msg_off_t'($urandom_range(BC_WORDS - 1, 0));
      dmem_write(BC_BASE + widx_t'(off), strb_t'($urandom_range(15, 1)), word_t'($urandom));
      msg_drive(off, strb_t'($urandom_range(15, 1)), word_t'($urandom));
      dmem_read(BC_BASE + widx_t'(off));
    end

    // Checksum accumulation
    acc_read(ACC_REG_SUM);
    acc_read(ACC_REG_COUNT);
    acc_write(ACC_REG_SUM, STRB_FULL, word_t'($urandom));
    acc_read(ACC_REG_COUNT);
    for (int i = 0; i < 24; i++) begin
      acc_write(ACC_REG_DATA, STRB_FULL, word_t'($urandom));
    end
    acc_read(ACC_REG_SUM);
    acc_read(ACC_REG_COUNT);
    acc_read(ACC_REG_DATA);
    check_err(ext_io_err, 1'b0, "error flag after good accesses");

    // Bad accesses must leave the registers unchanged
    acc_read(8'h0c);
    wait_err(1'b1, "error flag after unknown offset read");
    repeat (3) @(negedge clk);
    check_err(ext_io_err, 1'b1, "error flag held without ack");
    ack_err();
    acc_write(8'h10, STRB_FULL, word_t'($urandom));
    wait_err(1'b1, "error flag after unknown offset write");
    ack_err();
    acc_write(ACC_REG_DATA, 4'b0111, word_t'($urandom));
    wait_err(1'b1, "error flag after partial DATA write");
    ack_err();
    acc_read(ACC_REG_SUM);
    acc_read(ACC_REG_COUNT);
    check_err(ext_io_err, 1'b0, "error flag at end of run");

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: riscv_block.f
hdl/mem_map_pkg.sv
hdl/accel_pkg.sv
hdl/data_mem.sv
hdl/csum_accel.sv
hdl/core_port.sv
hdl/riscv_block.sv
bench/riscv_block_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the riscv_block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module riscv_block_tb \
  -f riscv_block.f \
  -o riscv_block_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/riscv_block_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi
exit 0
